/* src/flight_consts.svh */
// Widths, throttle limits, scaling breakpoints and pulse timing constants
`ifndef FLIGHT_CONSTS_SVH
`define FLIGHT_CONSTS_SVH

// Datapath widths
`define REC_VAL_BIT_WIDTH 8
`define OPS_BIT_WIDTH 16

// Throttle range in receiver counts
`define THR_IDLE_MAX 10
`define THR_MAX 250

// Breakpoints of the three-segment throttle curve
`define THR_MID_LOW 42
`define THR_MID_HIGH 209

// Largest throttle step per controller update
`define THR_CHANGE_LIMIT 5

// Receiver pulse, one count per RX_STEP_US above the minimum width
`define RX_MIN_PULSE_US 1000
`define RX_STEP_US 4
`define RX_TIMEOUT_US 2600

// ESC output frame and pulse width
`define ESC_FRAME_US 2500
`define ESC_MIN_PULSE_US 1000
`define ESC_STEP_US 4

`endif

/* src/flight_pkg.sv */
// Package with the throttle type, receiver sample and controller status structs
`default_nettype none

`include "flight_consts.svh"

package flight_pkg;

	// Throttle or receiver value as seen at module boundaries
	typedef logic [`REC_VAL_BIT_WIDTH-1:0] throttle_t;

	// One finished receiver measurement
	// valid is a single-cycle strobe, value holds until the next one
	typedef struct packed {
		throttle_t value;
		logic      valid;
	} rx_sample_t;

	// Throttle controller progress
	// active spans de-glitch through assign, complete is a one-cycle pulse
	typedef struct packed {
		logic active;
		logic complete;
	} tc_status_t;

endpackage

`default_nettype wire

/* src/rx_pulse_capture.sv */
// Receiver pulse capture, converts high time into a clamped receiver sample
`timescale 1ns/1ps
`default_nettype none

`include "flight_consts.svh"

module rx_pulse_capture (
	input  wire                     us_clk,
	input  wire                     resetn,
	input  wire                     rx_pwm,
	output flight_pkg::rx_sample_t  sample
);

	import flight_pkg::*;

	localparam int RW = `REC_VAL_BIT_WIDTH;
	localparam int OW = `OPS_BIT_WIDTH;

	localparam logic [OW-1:0] MIN_US     = OW'(`RX_MIN_PULSE_US);
	localparam logic [OW-1:0] STEP_US    = OW'(`RX_STEP_US);
	localparam logic [OW-1:0] TIMEOUT_US = OW'(`RX_TIMEOUT_US);
	localparam logic [OW-1:0] MAX_OPS    = OW'(`THR_MAX);
	localparam throttle_t     MAX_VAL    = RW'(`THR_MAX);

	// Two-stage synchronizer plus one stage for edge detection
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic rx_fall;

	// High time in microseconds, saturates one past the timeout
	logic [OW-1:0] high_us;
	logic [OW-1:0] excess_us;
	logic [OW-1:0] step_cnt;
	throttle_t     rx_value;

	assign rx_fall = rx_prev && !rx_sync;

	// Width to receiver counts, short pulses read as zero
	always_comb begin
		if (high_us > MIN_US) begin
			excess_us = high_us - MIN_US;
		end else begin
			excess_us = '0;
		end
		step_cnt = excess_us / STEP_US;
		if (step_cnt > MAX_OPS) begin
			rx_value = MAX_VAL;
		end else begin
			rx_value = step_cnt[RW-1:0];
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rx_meta <= 1'b0;
			rx_sync <= 1'b0;
			rx_prev <= 1'b0;
			high_us <= '0;
			sample  <= '0;
		end else begin
			rx_meta      <= rx_pwm;
			rx_sync      <= rx_meta;
			rx_prev      <= rx_sync;
			sample.valid <= 1'b0;

			// First high cycle restarts the count
			if (rx_sync && !rx_prev) begin
				high_us <= OW'(1);
			end else if (rx_sync && high_us <= TIMEOUT_US) begin
				high_us <= high_us + OW'(1);
			end

			// A pulse past the timeout is dropped without a strobe
			if (rx_fall && high_us <= TIMEOUT_US) begin
				sample.value <= rx_value;
				sample.valid <= 1'b1;
			end
		end
	end

	// Strobes are separated by at least one full pulse
	assert property (@(posedge us_clk) disable iff (!resetn)
		sample.valid |=> !sample.valid);

endmodule

`default_nettype wire

/* src/throttle_controller.sv */
// Throttle controller FSM with de-glitch, three-segment scaling and rate limit
`timescale 1ns/1ps
`default_nettype none

`include "flight_consts.svh"

module throttle_controller (
	input  wire                     us_clk,
	input  wire                     resetn,
	input  wire flight_pkg::rx_sample_t sample,
	input  wire                     imu_ready,
	input  wire                     tc_enable_n,
	output flight_pkg::throttle_t   throttle,
	output flight_pkg::tc_status_t  status
);

	import flight_pkg::*;

	localparam int RW = `REC_VAL_BIT_WIDTH;
	localparam int OW = `OPS_BIT_WIDTH;

	// One-hot states
	localparam logic [6:0] S_INIT          = 7'b0000001;
	localparam logic [6:0] S_WAITING       = 7'b0000010;
	localparam logic [6:0] S_DEGLITCH      = 7'b0000100;
	localparam logic [6:0] S_LINEAR_SCALE  = 7'b0001000;
	localparam logic [6:0] S_CHANGE_LIMIT  = 7'b0010000;
	localparam logic [6:0] S_ASSIGN_OUTPUT = 7'b0100000;
	localparam logic [6:0] S_COMPLETE      = 7'b1000000;

	localparam throttle_t IDLE_VAL  = RW'(`THR_IDLE_MAX);
	localparam throttle_t MAX_VAL   = RW'(`THR_MAX);
	localparam throttle_t LIMIT_VAL = RW'(`THR_CHANGE_LIMIT);

	localparam logic [OW-1:0] IDLE_OPS     = OW'(`THR_IDLE_MAX);
	localparam logic [OW-1:0] MAX_OPS      = OW'(`THR_MAX);
	localparam logic [OW-1:0] LIMIT_OPS    = OW'(`THR_CHANGE_LIMIT);
	localparam logic [OW-1:0] MID_LOW_OPS  = OW'(`THR_MID_LOW);
	localparam logic [OW-1:0] MID_HIGH_OPS = OW'(`THR_MID_HIGH);
	// Offsets that join the three curve segments
	localparam logic [OW-1:0] HIGH_OFFSET  = OW'(252);
	localparam logic [OW-1:0] MID_OFFSET   = OW'(61);

	logic [6:0] state;
	logic [6:0] next_state;
	logic       start_flag;

	// Pipeline of the throttle through the update
	throttle_t     latched_throttle;
	throttle_t     debounced_throttle;
	logic [OW-1:0] scaled_throttle;
	throttle_t     limited_throttle;

	// History for de-glitch and rate limit
	throttle_t     prev_latched_throttle;
	throttle_t     prev_throttle;

	logic [OW-1:0] deb_ops;
	logic [OW-1:0] prev_ops;

	assign deb_ops  = {{(OW-RW){1'b0}}, debounced_throttle};
	assign prev_ops = {{(OW-RW){1'b0}}, prev_throttle};

	// One pending request at most, nothing is queued before the IMU is up
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (state == S_INIT) begin
			start_flag <= 1'b0;
		end else if (state == S_WAITING && start_flag) begin
			start_flag <= sample.valid;
		end else if (sample.valid) begin
			start_flag <= 1'b1;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_INIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			S_INIT:          next_state = imu_ready ? S_WAITING : S_INIT;
			S_WAITING:       next_state = start_flag ? S_DEGLITCH : S_WAITING;
			S_DEGLITCH:      next_state = S_LINEAR_SCALE;
			S_LINEAR_SCALE:  next_state = S_CHANGE_LIMIT;
			S_CHANGE_LIMIT:  next_state = S_ASSIGN_OUTPUT;
			S_ASSIGN_OUTPUT: next_state = S_COMPLETE;
			S_COMPLETE:      next_state = S_WAITING;
			default:         next_state = S_INIT;
		endcase
	end

	// Status levels decoded straight from the state
	always_comb begin
		status.active   = (state == S_DEGLITCH) || (state == S_LINEAR_SCALE) ||
			(state == S_CHANGE_LIMIT) || (state == S_ASSIGN_OUTPUT);
		status.complete = (state == S_COMPLETE);
	end

	// Throttle pipeline, one stage per state
	always_ff @(posedge us_clk) begin
		case (state)
			S_WAITING: begin
				if (start_flag) begin
					if (sample.value < IDLE_VAL) begin
						latched_throttle <= '0;
					end else if (sample.value > MAX_VAL) begin
						latched_throttle <= MAX_VAL;
					end else begin
						latched_throttle <= sample.value;
					end
				end
			end
			S_DEGLITCH: begin
				// A lone idle reading after flight keeps the last value
				if (latched_throttle <= IDLE_VAL && prev_latched_throttle > IDLE_VAL) begin
					debounced_throttle <= prev_latched_throttle;
				end else begin
					debounced_throttle <= latched_throttle;
				end
			end
			S_LINEAR_SCALE: begin
				if (deb_ops < MID_LOW_OPS) begin
					scaled_throttle <= deb_ops << 1;
				end else if (deb_ops > MID_HIGH_OPS) begin
					scaled_throttle <= (deb_ops << 1) - HIGH_OFFSET;
				end else begin
					scaled_throttle <= (deb_ops >> 1) + MID_OFFSET;
				end
			end
			S_CHANGE_LIMIT: begin
				if (scaled_throttle < IDLE_OPS) begin
					limited_throttle <= '0;
				end else if (scaled_throttle > prev_ops + LIMIT_OPS) begin
					// Rising too fast
					if (prev_ops + LIMIT_OPS > MAX_OPS) begin
						limited_throttle <= MAX_VAL;
					end else begin
						limited_throttle <= prev_throttle + LIMIT_VAL;
					end
				end else if (prev_ops > scaled_throttle + LIMIT_OPS) begin
					// Falling too fast
					if (prev_ops - LIMIT_OPS < IDLE_OPS) begin
						limited_throttle <= '0;
					end else begin
						limited_throttle <= prev_throttle - LIMIT_VAL;
					end
				end else if (scaled_throttle > MAX_OPS) begin
					limited_throttle <= MAX_VAL;
				end else begin
					limited_throttle <= scaled_throttle[RW-1:0];
				end
			end
			default: begin
			end
		endcase
	end

	// Output and history registers
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle              <= '0;
			prev_latched_throttle <= '0;
			prev_throttle         <= '0;
		end else begin
			case (state)
				S_INIT: begin
					throttle <= '0;
				end
				S_DEGLITCH: begin
					prev_latched_throttle <= latched_throttle;
				end
				S_ASSIGN_OUTPUT: begin
					// tc_enable_n high bypasses the shaping
					throttle <= tc_enable_n ? latched_throttle : limited_throttle;
				end
				S_COMPLETE: begin
					prev_throttle <= throttle;
				end
				default: begin
				end
			endcase
		end
	end

	assert property (@(posedge us_clk) disable iff (!resetn) $onehot(state));

	// Every complete closes an active update
	assert property (@(posedge us_clk) disable iff (!resetn)
		status.complete |-> !status.active && $past(status.active));

endmodule

`default_nettype wire

/* src/esc_pulse_gen.sv */
// ESC pulse generator with a fixed frame and throttle-controlled high time
`timescale 1ns/1ps
`default_nettype none

`include "flight_consts.svh"

module esc_pulse_gen (
	input  wire                   us_clk,
	input  wire                   resetn,
	input  wire flight_pkg::throttle_t throttle,
	output logic                  esc_pwm
);

	localparam int RW = `REC_VAL_BIT_WIDTH;
	localparam int OW = `OPS_BIT_WIDTH;

	localparam logic [OW-1:0] FRAME_LAST = OW'(`ESC_FRAME_US - 1);
	localparam logic [OW-1:0] MIN_US     = OW'(`ESC_MIN_PULSE_US);
	localparam logic [OW-1:0] STEP_US    = OW'(`ESC_STEP_US);
	localparam logic [OW-1:0] MAX_WIDTH  = OW'(`ESC_MIN_PULSE_US + `ESC_STEP_US * `THR_MAX);

	logic [OW-1:0] frame_cnt;
	logic [OW-1:0] width_us;
	logic [OW-1:0] width_next;
	logic          frame_start;

	assign frame_start = (frame_cnt == FRAME_LAST);
	assign width_next  = MIN_US + STEP_US * {{(OW-RW){1'b0}}, throttle};

	// Counter starts on the last count so the first frame begins right after reset
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			frame_cnt <= FRAME_LAST;
			esc_pwm   <= 1'b0;
		end else if (frame_start) begin
			frame_cnt <= '0;
			esc_pwm   <= 1'b1;
		end else begin
			frame_cnt <= frame_cnt + OW'(1);
			esc_pwm   <= (frame_cnt + OW'(1)) < width_us;
		end
	end

	// Width is frozen for the whole frame
	always_ff @(posedge us_clk) begin
		if (frame_start) begin
			width_us <= width_next;
		end
	end

	// Pulse never outlasts the full-throttle width
	assert property (@(posedge us_clk) disable iff (!resetn)
		esc_pwm |-> frame_cnt < MAX_WIDTH);

endmodule

`default_nettype wire

/* src/throttle_path_top.sv */
// Throttle path top level joining capture, controller and ESC pulse generator
`timescale 1ns/1ps
`default_nettype none

module throttle_path_top (
	input  wire                        us_clk,
	input  wire                        resetn,
	input  wire                        rx_pwm,
	input  wire                        imu_ready,
	input  wire                        tc_enable_n,
	output wire                        esc_pwm,
	output wire flight_pkg::throttle_t  throttle,
	output wire flight_pkg::tc_status_t status
);

	import flight_pkg::*;

	// Receiver measurement into the controller
	wire rx_sample_t rx_sample;

	rx_pulse_capture i_capture (
		.us_clk (us_clk),
		.resetn (resetn),
		.rx_pwm (rx_pwm),
		.sample (rx_sample)
	);

	throttle_controller i_controller (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.sample      (rx_sample),
		.imu_ready   (imu_ready),
		.tc_enable_n (tc_enable_n),
		.throttle    (throttle),
		.status      (status)
	);

	// Motor pulse follows the controller output, sampled once per frame
	esc_pulse_gen i_esc (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.throttle (throttle),
		.esc_pwm  (esc_pwm)
	);

endmodule

`default_nettype wire

/* tb/tb_throttle_path.sv */
// Testbench for the throttle path with a stimulus table, reference model and ESC pulse checks
`timescale 1ns/1ps
`default_nettype none

`include "flight_consts.svh"

module tb_throttle_path;

	import flight_pkg::*;

	localparam int COMPLETE_TIMEOUT = 60;
	localparam int FRAME_TIMEOUT    = 2 * `ESC_FRAME_US + 20;
	localparam int HIGH_TIMEOUT     = `ESC_FRAME_US;

	logic       us_clk = 1'b0;
	logic       resetn;
	logic       rx_pwm;
	logic       imu_ready;
	logic       tc_enable_n;
	logic       esc_pwm;
	throttle_t  throttle;
	tc_status_t status;

	// Stimulus table, one row per receiver pulse
	string tbl_name[$];
	int    tbl_width[$];
	logic  tbl_enable_n[$];
	logic  tbl_imu_ready[$];

	// Reference model history
	int model_prev_latched;
	int model_prev_out;
	int model_out;

	int value_errors;
	int event_errors;

	throttle_path_top i_dut (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.rx_pwm      (rx_pwm),
		.imu_ready   (imu_ready),
		.tc_enable_n (tc_enable_n),
		.esc_pwm     (esc_pwm),
		.throttle    (throttle),
		.status      (status)
	);

	initial begin
		forever #2 us_clk = ~us_clk;
	end

	task automatic add_entry(input string name, input int width, input logic enable_n,
		input logic ready);
		tbl_name.push_back(name);
		tbl_width.push_back(width);
		tbl_enable_n.push_back(enable_n);
		tbl_imu_ready.push_back(ready);
	endtask

	task automatic build_table();
		int level;
		add_entry("imu_not_ready", 1500, 1'b1, 1'b0);
		add_entry("imu_not_ready_shaped", 1800, 1'b0, 1'b0);
		add_entry("bypass_mid", 1500, 1'b1, 1'b1);
		add_entry("bypass_long", 1900, 1'b1, 1'b1);
		add_entry("bypass_over_range", 2200, 1'b1, 1'b1);
		// Held past the receiver timeout, so no update at all
		add_entry("bypass_lost_pulse", 2700, 1'b1, 1'b1);
		add_entry("bypass_short", 900, 1'b1, 1'b1);
		add_entry("bypass_preset", 1080, 1'b1, 1'b1);
		// Two counts per step keeps every segment within the rate limit
		for (level = 12; level <= `THR_MAX; level += 2) begin
			add_entry($sformatf("ramp_%0d", level), `RX_MIN_PULSE_US + `RX_STEP_US * level,
				1'b0, 1'b1);
		end
		repeat (3) add_entry("step_down", 1400, 1'b0, 1'b1);
		repeat (3) add_entry("step_up", 2000, 1'b0, 1'b1);
		add_entry("bypass_steady", 1544, 1'b1, 1'b1);
		repeat (2) add_entry("steady", 1600, 1'b0, 1'b1);
		add_entry("idle_glitch", 900, 1'b0, 1'b1);
		add_entry("idle_second", 900, 1'b0, 1'b1);
		add_entry("rise_from_idle", 1400, 1'b0, 1'b1);
	endtask

	// Receiver counts for a pulse width in microseconds
	function automatic int receiver_counts(input int width_us);
		int counts;
		counts = 0;
		if (width_us > `RX_MIN_PULSE_US) begin
			counts = (width_us - `RX_MIN_PULSE_US) / `RX_STEP_US;
		end
		if (counts > `THR_MAX) begin
			counts = `THR_MAX;
		end
		return counts;
	endfunction

	// Three-segment throttle curve
	function automatic int curve_value(input int level);
		int result;
		if (level < `THR_MID_LOW) begin
			result = 2 * level;
		end else if (level > `THR_MID_HIGH) begin
			result = 2 * level - 252;
		end else begin
			result = level / 2 + 61;
		end
		return result;
	endfunction

	function automatic int rate_limit(input int target, input int prev);
		int result;
		if (target < `THR_IDLE_MAX) begin
			result = 0;
		end else if (target - prev > `THR_CHANGE_LIMIT) begin
			result = prev + `THR_CHANGE_LIMIT;
			if (result > `THR_MAX) begin
				result = `THR_MAX;
			end
		end else if (prev - target > `THR_CHANGE_LIMIT) begin
			result = prev - `THR_CHANGE_LIMIT;
			if (result < `THR_IDLE_MAX) begin
				result = 0;
			end
		end else if (target > `THR_MAX) begin
			result = `THR_MAX;
		end else begin
			result = target;
		end
		return result;
	endfunction

	// One controller update in the reference model
	task automatic apply_model(input int counts, input logic bypass);
		int latched;
		int settled;
		latched = counts;
		if (counts < `THR_IDLE_MAX) begin
			latched = 0;
		end else if (counts > `THR_MAX) begin
			latched = `THR_MAX;
		end
		settled = latched;
		if (latched <= `THR_IDLE_MAX && model_prev_latched > `THR_IDLE_MAX) begin
			settled = model_prev_latched;
		end
		model_prev_latched = latched;
		if (bypass) begin
			model_out = latched;
		end else begin
			model_out = rate_limit(curve_value(settled), model_prev_out);
		end
		model_prev_out = model_out;
	endtask

	// Called on a falling edge, returns on the falling edge that ends the pulse
	task automatic send_pulse(input int width);
		rx_pwm = 1'b1;
		repeat (width) @(negedge us_clk);
		rx_pwm = 1'b0;
	endtask

	// Also returns the status sampled on the cycle before complete
	task automatic wait_complete(input string name, input bit expected, output bit seen,
		output tc_status_t last_busy);
		int         cycles;
		tc_status_t sampled;
		seen = 1'b0;
		cycles = 0;
		sampled = '0;
		last_busy = '0;
		while (!seen && cycles < COMPLETE_TIMEOUT) begin
			last_busy = sampled;
			@(negedge us_clk);
			sampled = status;
			seen = sampled.complete;
			cycles++;
		end
		if (expected && !seen) begin
			event_errors++;
			$display("%s: no complete pulse from the controller within %0d cycles",
				name, COMPLETE_TIMEOUT);
		end else if (!expected && seen) begin
			event_errors++;
			$display("%s: the controller completed an update it should not have made", name);
		end
	endtask

	// High time of the first ESC frame that starts after the call
	task automatic measure_esc(input string name, output int high_time, output bit found);
		int cycles;
		found = 1'b0;
		high_time = 0;
		cycles = 0;
		while (esc_pwm && cycles < FRAME_TIMEOUT) begin
			@(negedge us_clk);
			cycles++;
		end
		cycles = 0;
		while (!esc_pwm && cycles < FRAME_TIMEOUT) begin
			@(negedge us_clk);
			cycles++;
		end
		while (esc_pwm && high_time < HIGH_TIMEOUT) begin
			high_time++;
			@(negedge us_clk);
		end
		if (high_time == 0 || esc_pwm) begin
			event_errors++;
			$display("%s: no complete ESC pulse seen within the frame timeout", name);
		end else begin
			found = 1'b1;
		end
	endtask

	task automatic check_throttle(input string name, input throttle_t expected,
		input throttle_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] %s throttle expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_status(input string name, input tc_status_t expected,
		input tc_status_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] %s status expected active=%0b complete=%0b actual active=%0b complete=%0b",
				name, expected.active, expected.complete, actual.active, actual.complete);
		end
	endtask

	task automatic check_pulse(input string name, input int expected, input int actual);
		if (actual != expected) begin
			value_errors++;
			$display("[FAIL] %s esc_pwm high time expected %0d actual %0d", name, expected, actual);
		end
	endtask

	initial begin
		int         idx;
		int         rnd;
		int         gap;
		int         high_time;
		bit         seen;
		bit         found;
		bit         update;
		bit         running;
		tc_status_t done_status;
		tc_status_t idle_status;
		tc_status_t busy_status;
		tc_status_t before_status;

		value_errors = 0;
		event_errors = 0;
		model_prev_latched = 0;
		model_prev_out = 0;
		model_out = 0;
		running = 1'b0;
		done_status.active = 1'b0;
		done_status.complete = 1'b1;
		busy_status.active = 1'b1;
		busy_status.complete = 1'b0;
		idle_status = '0;

		resetn = 1'b0;
		rx_pwm = 1'b0;
		imu_ready = 1'b0;
		tc_enable_n = 1'b1;
		rnd = $urandom(32'ha7d);
		build_table();

		repeat (4) @(negedge us_clk);
		resetn = 1'b1;

		for (idx = 0; idx < tbl_name.size(); idx++) begin
			@(negedge us_clk);
			imu_ready = tbl_imu_ready[idx];
			tc_enable_n = tbl_enable_n[idx];
			// The controller leaves init once the IMU is ready and never returns
			if (tbl_imu_ready[idx]) begin
				running = 1'b1;
			end
			gap = 4 + int'($urandom % 16);
			repeat (gap) @(negedge us_clk);
			send_pulse(tbl_width[idx]);

			update = running && (tbl_width[idx] <= `RX_TIMEOUT_US);
			if (update) begin
				apply_model(receiver_counts(tbl_width[idx]), tbl_enable_n[idx]);
			end
			wait_complete(tbl_name[idx], update, seen, before_status);
			if (update && seen) begin
				// Assign state just before complete still counts as active
				check_status(tbl_name[idx], busy_status, before_status);
				check_status(tbl_name[idx], done_status, status);
				check_throttle(tbl_name[idx], throttle_t'(model_out), throttle);
				@(negedge us_clk);
				check_status(tbl_name[idx], idle_status, status);
			end else begin
				check_status(tbl_name[idx], idle_status, status);
				check_throttle(tbl_name[idx], throttle_t'(model_out), throttle);
			end

			measure_esc(tbl_name[idx], high_time, found);
			if (found) begin
				check_pulse(tbl_name[idx], `ESC_MIN_PULSE_US + `ESC_STEP_US * model_out,
					high_time);
			end
		end

		$display("Errors: %0d value mismatches, %0d timeouts or missed events",
			value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/flight_pkg.sv
src/rx_pulse_capture.sv
src/throttle_controller.sv
src/esc_pulse_gen.sv
src/throttle_path_top.sv
tb/tb_throttle_path.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the throttle path testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_throttle_path \
	-f all.f -o tb_sim > sim.log 2>&1 &&
	./obj_dir/tb_sim >> sim.log 2>&1

cat sim.log
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
